/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [29:0] pc_t;

    // ----------------------------------------------------------
    // Major opcodes
    // ----------------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // ----------------------------------------------------------
    // funct3 codes
    // ----------------------------------------------------------
    localparam logic [2:0] F3_ADD    = 3'b000;
    localparam logic [2:0] F3_SLL    = 3'b001;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_SRL    = 3'b101;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;
    localparam logic [2:0] F3_BEQ    = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

endpackage

/* rtl/rv_core_pkg.sv */
package rv_core_pkg;

    localparam rv_isa_pkg::word_t RESET_ADDR = 32'h0000_0000;

    typedef enum logic [2:0] {
        ST_FETCH   = 3'd1,
        ST_DECODE  = 3'd2,
        ST_EXECUTE = 3'd3,
        ST_MEMORY  = 3'd4,
        ST_WRITE   = 3'd5
    } stage_e;

    typedef enum logic [1:0] {
        RES_ALU  = 2'd0,
        RES_LOAD = 2'd1,
        RES_LINK = 2'd2
    } res_src_e;

    // ----------------------------------------------------------
    // Stage-to-stage records
    // ----------------------------------------------------------
    typedef struct packed {
        rv_isa_pkg::pc_t     pc;
        rv_isa_pkg::pc_t     pc_p4;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t   imm;
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
        res_src_e            res_src;
        logic                branch;
        logic                jump;
        logic                op2_imm;
        logic [2:0]          funct3;
        rv_isa_pkg::alu_op_e alu_op;
    } id_ex_t;

    typedef struct packed {
        rv_isa_pkg::word_t    alu_result;
        rv_isa_pkg::word_t    rs2_val;
        rv_isa_pkg::reg_idx_t rd;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        res_src_e             res_src;
        logic [2:0]           funct3;
        rv_isa_pkg::pc_t      pc_p4;
        logic                 pc_src;
        rv_isa_pkg::pc_t      pc_target;
    } ex_mem_t;

    typedef struct packed {
        rv_isa_pkg::word_t    alu_result;
        rv_isa_pkg::reg_idx_t rd;
        logic                 reg_write;
        res_src_e             res_src;
        logic [2:0]           funct3;
        rv_isa_pkg::pc_t      pc_p4;
    } mem_wb_t;

endpackage

/* rtl/rv_fetch.sv */
`timescale 1ns/1ns

module rv_fetch
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_en,
    input  logic            i_pc_src,
    input  rv_isa_pkg::pc_t i_pc_target,
    output rv_isa_pkg::pc_t o_pc,
    output rv_isa_pkg::pc_t o_pc_p4
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    pc_t r_pc;

    // The PC counts words, so the sequential step is one.
    assign o_pc    = r_pc;
    assign o_pc_p4 = r_pc + 30'd1;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_pc <= RESET_ADDR[31:2];
        else if (i_en)
            r_pc <= i_pc_src ? i_pc_target : o_pc_p4;
    end

endmodule

/* rtl/rv_decode.sv */
`timescale 1ns/1ns

module rv_decode
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_fetch_en,
    input  logic                  i_decode_en,
    input  rv_isa_pkg::word_t     i_data,
    input  rv_isa_pkg::pc_t       i_pc,
    input  rv_isa_pkg::pc_t       i_pc_p4,
    output rv_isa_pkg::reg_idx_t  o_rs1,
    output rv_isa_pkg::reg_idx_t  o_rs2,
    output rv_core_pkg::id_ex_t   o_id_ex
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    word_t      r_instr;
    word_t      w_imm_i, w_imm_s, w_imm_b, w_imm_u, w_imm_j;
    logic [6:0] w_opcode;
    logic [2:0] w_funct3;
    id_ex_t     w_dec;

    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic sub);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = sub ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_XOR:  op = ALU_XOR;
            F3_SRL:  op = ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_fetch_en)
            r_instr <= i_data;
    end

    assign w_opcode = r_instr[6:0];
    assign w_funct3 = r_instr[14:12];
    assign o_rs1    = r_instr[19:15];
    assign o_rs2    = r_instr[24:20];

    assign w_imm_i = {{20{r_instr[31]}}, r_instr[31:20]};
    assign w_imm_s = {{20{r_instr[31]}}, r_instr[31:25], r_instr[11:7]};
    assign w_imm_b = {{19{r_instr[31]}}, r_instr[31], r_instr[7], r_instr[30:25],
                      r_instr[11:8], 1'b0};
    assign w_imm_u = {r_instr[31:12], 12'b0};
    assign w_imm_j = {{11{r_instr[31]}}, r_instr[31], r_instr[19:12], r_instr[20],
                      r_instr[30:21], 1'b0};

    // Anything not listed below falls through as a no-op.
    always_comb
    begin
        w_dec        = '0;
        w_dec.pc     = i_pc;
        w_dec.pc_p4  = i_pc_p4;
        w_dec.rd     = r_instr[11:7];
        w_dec.funct3 = w_funct3;
        case (w_opcode)
            OPC_OP:
            begin
                w_dec.reg_write = 1'b1;
                w_dec.alu_op    = f3_to_alu(w_funct3, r_instr[30]);
            end
            OPC_OP_IMM:
            begin
                w_dec.reg_write = 1'b1;
                w_dec.op2_imm   = 1'b1;
                w_dec.imm       = w_imm_i;
                w_dec.alu_op    = f3_to_alu(w_funct3, 1'b0);
            end
            OPC_LUI:
            begin
                w_dec.reg_write = 1'b1;
                w_dec.op2_imm   = 1'b1;
                w_dec.imm       = w_imm_u;
                w_dec.alu_op    = ALU_PASS_B;
            end
            OPC_LOAD:
            begin
                w_dec.reg_write = 1'b1;
                w_dec.mem_read  = 1'b1;
                w_dec.res_src   = RES_LOAD;
                w_dec.op2_imm   = 1'b1;
                w_dec.imm       = w_imm_i;
            end
            OPC_STORE:
            begin
                w_dec.mem_write = 1'b1;
                w_dec.op2_imm   = 1'b1;
                w_dec.imm       = w_imm_s;
            end
            OPC_BRANCH:
            begin
                w_dec.branch = 1'b1;
                w_dec.imm    = w_imm_b;
            end
            OPC_JAL:
            begin
                w_dec.jump      = 1'b1;
                w_dec.reg_write = 1'b1;
                w_dec.res_src   = RES_LINK;
                w_dec.imm       = w_imm_j;
            end
            default:
            begin
                w_dec.rd = '0;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            o_id_ex <= '0;
        else if (i_decode_en)
            o_id_ex <= w_dec;
    end

endmodule

/* rtl/rv_exec.sv */
`timescale 1ns/1ns

module rv_exec
(
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_en,
    input  rv_core_pkg::id_ex_t  i_id_ex,
    input  rv_isa_pkg::word_t    i_rs1_val,
    input  rv_isa_pkg::word_t    i_rs2_val,
    output rv_core_pkg::ex_mem_t o_ex_mem
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    word_t   w_op_b;
    word_t   w_alu;
    logic    w_taken;
    ex_mem_t w_ex_mem;

    assign w_op_b = i_id_ex.op2_imm ? i_id_ex.imm : i_rs2_val;

    always_comb
    begin
        case (i_id_ex.alu_op)
            ALU_SUB:    w_alu = i_rs1_val - w_op_b;
            ALU_AND:    w_alu = i_rs1_val & w_op_b;
            ALU_OR:     w_alu = i_rs1_val | w_op_b;
            ALU_XOR:    w_alu = i_rs1_val ^ w_op_b;
            ALU_SLT:    w_alu = {31'b0, $signed(i_rs1_val) < $signed(w_op_b)};
            ALU_SLL:    w_alu = i_rs1_val << w_op_b[4:0];
            ALU_SRL:    w_alu = i_rs1_val >> w_op_b[4:0];
            ALU_PASS_B: w_alu = w_op_b;
            default:    w_alu = i_rs1_val + w_op_b;
        endcase
    end

    always_comb
    begin
        case (i_id_ex.funct3)
            F3_BEQ:  w_taken = i_id_ex.branch && (i_rs1_val == i_rs2_val);
            F3_BNE:  w_taken = i_id_ex.branch && (i_rs1_val != i_rs2_val);
            default: w_taken = 1'b0;
        endcase
    end

    always_comb
    begin
        w_ex_mem            = '0;
        w_ex_mem.alu_result = w_alu;
        w_ex_mem.rs2_val    = i_rs2_val;
        w_ex_mem.rd         = i_id_ex.rd;
        w_ex_mem.reg_write  = i_id_ex.reg_write;
        w_ex_mem.mem_read   = i_id_ex.mem_read;
        w_ex_mem.mem_write  = i_id_ex.mem_write;
        w_ex_mem.res_src    = i_id_ex.res_src;
        w_ex_mem.funct3     = i_id_ex.funct3;
        w_ex_mem.pc_p4      = i_id_ex.pc_p4;
        w_ex_mem.pc_src     = w_taken | i_id_ex.jump;
        w_ex_mem.pc_target  = i_id_ex.pc + i_id_ex.imm[31:2];
    end

    // Out of reset the first fetch enable reloads the reset address.
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_ex_mem           <= '0;
            o_ex_mem.pc_src    <= 1'b1;
            o_ex_mem.pc_target <= RESET_ADDR[31:2];
        end
        else if (i_en)
            o_ex_mem <= w_ex_mem;
    end

endmodule

/* rtl/rv_memory.sv */
`timescale 1ns/1ns

module rv_memory
(
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  logic                 i_en,
    input  rv_core_pkg::ex_mem_t i_ex_mem,
    input  rv_isa_pkg::word_t    i_rdata,
    output logic [3:0]           o_sel,
    output rv_isa_pkg::word_t    o_wdata,
    output rv_core_pkg::mem_wb_t o_mem_wb,
    output rv_isa_pkg::word_t    o_load_data
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    logic w_word;

    assign w_word = (i_ex_mem.funct3 == F3_WORD);

    // A byte store is replicated so the selected lane always carries it.
    assign o_sel   = w_word ? 4'b1111 : (4'b0001 << i_ex_mem.alu_result[1:0]);
    assign o_wdata = w_word ? i_ex_mem.rs2_val : {4{i_ex_mem.rs2_val[7:0]}};

    always_ff @(posedge i_clk)
    begin
        if (i_en)
            o_load_data <= i_rdata;
        if (!i_reset_n)
            o_mem_wb <= '0;
        else if (i_en)
            o_mem_wb <= '{alu_result: i_ex_mem.alu_result, rd: i_ex_mem.rd,
                          reg_write: i_ex_mem.reg_write, res_src: i_ex_mem.res_src,
                          funct3: i_ex_mem.funct3, pc_p4: i_ex_mem.pc_p4};
    end

    a_word_aligned: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_en && (i_ex_mem.mem_read || i_ex_mem.mem_write) && w_word
        |-> i_ex_mem.alu_result[1:0] == 2'b00);

endmodule

/* rtl/rv_write.sv */
`timescale 1ns/1ns

module rv_write
(
    input  rv_core_pkg::mem_wb_t  i_mem_wb,
    input  rv_isa_pkg::word_t     i_load_data,
    output logic                  o_we,
    output rv_isa_pkg::reg_idx_t  o_rd,
    output rv_isa_pkg::word_t     o_wdata
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    word_t w_shifted;
    word_t w_load;

    assign w_shifted = i_load_data >> {i_mem_wb.alu_result[1:0], 3'b000};
    assign w_load    = (i_mem_wb.funct3 == F3_BYTE_U) ? {24'b0, w_shifted[7:0]} : i_load_data;

    always_comb
    begin
        case (i_mem_wb.res_src)
            RES_LOAD: o_wdata = w_load;
            RES_LINK: o_wdata = {i_mem_wb.pc_p4, 2'b00};
            default:  o_wdata = i_mem_wb.alu_result;
        endcase
    end

    assign o_we = i_mem_wb.reg_write && (i_mem_wb.rd != 5'd0);
    assign o_rd = i_mem_wb.rd;

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile
(
    input  logic                 i_clk,
    input  logic                 i_we,
    input  rv_isa_pkg::reg_idx_t i_rd,
    input  rv_isa_pkg::word_t    i_wdata,
    input  rv_isa_pkg::reg_idx_t i_rs1,
    input  rv_isa_pkg::reg_idx_t i_rs2,
    output rv_isa_pkg::word_t    o_rs1_val,
    output rv_isa_pkg::word_t    o_rs2_val
);
    import rv_isa_pkg::*;

    // x0 has no storage.
    word_t r_regs [31:1];

    assign o_rs1_val = (i_rs1 != 5'd0) ? r_regs[i_rs1] : '0;
    assign o_rs2_val = (i_rs2 != 5'd0) ? r_regs[i_rs2] : '0;

    always_ff @(posedge i_clk)
    begin
        if (i_we && (i_rd != 5'd0))
            r_regs[i_rd] <= i_wdata;
    end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ns

module rv_core
(
    input  logic              i_clk,
    input  logic              i_reset_n,
    output rv_isa_pkg::word_t o_wb_adr,
    output rv_isa_pkg::word_t o_wb_dat,
    input  rv_isa_pkg::word_t i_wb_dat,
    output logic              o_wb_we,
    output logic [3:0]        o_wb_sel,
    output logic              o_wb_stb,
    input  logic              i_wb_ack,
    output logic              o_wb_cyc
);
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    stage_e   r_stage;
    stage_e   w_stage_next;
    pc_t      w_fetch_pc, w_fetch_pc_p4;
    reg_idx_t w_rs1, w_rs2;
    word_t    w_rs1_val, w_rs2_val;
    id_ex_t   w_id_ex;
    ex_mem_t  w_ex_mem;
    mem_wb_t  w_mem_wb;
    word_t    w_load_data;
    word_t    w_mem_wdata;
    logic [3:0] w_mem_sel;
    logic     w_wr_we;
    reg_idx_t w_wr_rd;
    word_t    w_wr_data;
    logic     w_data_access;

    // ----------------------------------------------------------
    // Stage sequencer with one instruction in flight
    // ----------------------------------------------------------
    always_comb
    begin
        case (r_stage)
            ST_FETCH:   w_stage_next = ST_DECODE;
            ST_DECODE:  w_stage_next = ST_EXECUTE;
            ST_EXECUTE: w_stage_next = ST_MEMORY;
            ST_MEMORY:  w_stage_next = ST_WRITE;
            default:    w_stage_next = ST_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_stage <= ST_WRITE;
        else
            r_stage <= w_stage_next;
    end

    rv_fetch u_st1_fetch (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_en(r_stage == ST_WRITE),
        .i_pc_src(w_ex_mem.pc_src), .i_pc_target(w_ex_mem.pc_target),
        .o_pc(w_fetch_pc), .o_pc_p4(w_fetch_pc_p4)
    );

    rv_decode u_st2_decode (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_fetch_en(r_stage == ST_FETCH), .i_decode_en(r_stage == ST_DECODE),
        .i_data(i_wb_dat), .i_pc(w_fetch_pc), .i_pc_p4(w_fetch_pc_p4),
        .o_rs1(w_rs1), .o_rs2(w_rs2), .o_id_ex(w_id_ex)
    );

    rv_exec u_st3_exec (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_en(r_stage == ST_EXECUTE),
        .i_id_ex(w_id_ex), .i_rs1_val(w_rs1_val), .i_rs2_val(w_rs2_val),
        .o_ex_mem(w_ex_mem)
    );

    rv_memory u_st4_memory (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_en(r_stage == ST_MEMORY),
        .i_ex_mem(w_ex_mem), .i_rdata(i_wb_dat), .o_sel(w_mem_sel),
        .o_wdata(w_mem_wdata), .o_mem_wb(w_mem_wb), .o_load_data(w_load_data)
    );

    rv_write u_st5_write (
        .i_mem_wb(w_mem_wb), .i_load_data(w_load_data),
        .o_we(w_wr_we), .o_rd(w_wr_rd), .o_wdata(w_wr_data)
    );

    rv_regfile u_regfile (
        .i_clk(i_clk), .i_we(w_wr_we && (r_stage == ST_WRITE)),
        .i_rd(w_wr_rd), .i_wdata(w_wr_data), .i_rs1(w_rs1), .i_rs2(w_rs2),
        .o_rs1_val(w_rs1_val), .o_rs2_val(w_rs2_val)
    );

    // ----------------------------------------------------------
    // Wishbone port shared by fetch and data access
    // ----------------------------------------------------------
    assign w_data_access = w_ex_mem.mem_read | w_ex_mem.mem_write;

    always_comb
    begin
        o_wb_adr = {w_fetch_pc, 2'b00};
        o_wb_sel = 4'b1111;
        o_wb_we  = 1'b0;
        o_wb_stb = 1'b0;
        case (r_stage)
            ST_FETCH:  o_wb_stb = 1'b1;
            ST_MEMORY:
            begin
                o_wb_adr = {w_ex_mem.alu_result[31:2], 2'b00};
                o_wb_sel = w_mem_sel;
                o_wb_we  = w_ex_mem.mem_write;
                o_wb_stb = w_data_access;
            end
            default:   o_wb_stb = 1'b0;
        endcase
    end

    assign o_wb_cyc = o_wb_stb;
    assign o_wb_dat = w_mem_wdata;

    // The core never waits, so the slave has to answer in the strobe cycle.
    a_zero_wait: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        o_wb_stb |-> i_wb_ack);

endmodule

/* dv/wb_ram_model.sv */
`timescale 1ns/1ns

module wb_ram_model
(
    input  logic        i_clk,
    input  logic        i_cyc,
    input  logic        i_stb,
    input  logic        i_we,
    input  logic [3:0]  i_sel,
    input  logic [31:0] i_adr,
    input  logic [31:0] i_dat,
    output logic [31:0] o_dat,
    output logic        o_ack
);

    // 1 KB of word storage, indexed by address bits 9 to 2.
    logic [31:0] mem [0:255];

    // Address of every bus write in the order it happened.
    logic [31:0] log_adr [$];

    // Zero wait states, so the strobe is answered in its own cycle.
    assign o_ack = i_cyc && i_stb;
    assign o_dat = mem[i_adr[9:2]];

    always @(posedge i_clk)
    begin
        if (i_cyc && i_stb && i_we)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (i_sel[b])
                    mem[i_adr[9:2]][8 * b +: 8] = i_dat[8 * b +: 8];
            end
            log_adr.push_back(i_adr);
        end
    end

endmodule

/* dv/rv_core_tb.sv */
`timescale 1ns/1ns

module rv_core_tb;
    import rv_isa_pkg::*;
    import rv_core_pkg::*;

    localparam int MARGIN = 50;

    logic       clk;
    logic       reset_n;
    word_t      wb_adr;
    word_t      wb_dat_w;
    word_t      wb_dat_r;
    logic       wb_we;
    logic [3:0] wb_sel;
    logic       wb_stb;
    logic       wb_ack;
    logic       wb_cyc;

    word_t      exp_fetch [$];
    word_t      exp_st_adr [$];
    word_t      exp_st_dat [$];
    logic [3:0] exp_st_sel [$];
    word_t      emit_pc;
    int         errors = 0;
    int         edge_cnt = 0;
    int         fetch_idx = 0;
    int         store_idx = 0;
    int         slot = -1;
    logic [6:0] fetched_opc;
    logic       data_due;

    rv_core rv_core_inst (
        .i_clk(clk), .i_reset_n(reset_n), .o_wb_adr(wb_adr), .o_wb_dat(wb_dat_w),
        .i_wb_dat(wb_dat_r), .o_wb_we(wb_we), .o_wb_sel(wb_sel), .o_wb_stb(wb_stb),
        .i_wb_ack(wb_ack), .o_wb_cyc(wb_cyc)
    );

    wb_ram_model ram (
        .i_clk(clk), .i_cyc(wb_cyc), .i_stb(wb_stb), .i_we(wb_we), .i_sel(wb_sel),
        .i_adr(wb_adr), .i_dat(wb_dat_w), .o_dat(wb_dat_r), .o_ack(wb_ack)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------
    // Instruction encoders and reference rules
    // ----------------------------------------------------------
    function automatic word_t rtype(input logic [6:0] f7, input reg_idx_t rs2, rs1,
                                    input logic [2:0] f3, input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t itype(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t stype(input logic [11:0] imm, input reg_idx_t rs2, rs1,
                                    input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t btype(input logic [12:0] imm, input reg_idx_t rs2, rs1,
                                    input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t utype(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t jtype(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Operation k in the order ADD, SUB, AND, OR, XOR, SLT, SLL, SRL.
    function automatic logic [2:0] op_funct3(input int k);
        case (k)
            0, 1:    return F3_ADD;
            2:       return F3_AND;
            3:       return F3_OR;
            4:       return F3_XOR;
            5:       return F3_SLT;
            6:       return F3_SLL;
            default: return F3_SRL;
        endcase
    endfunction

    function automatic word_t alu_rule(input int k, input word_t x, input word_t y);
        case (k)
            0:       return x + y;
            1:       return x - y;
            2:       return x & y;
            3:       return x | y;
            4:       return x ^ y;
            5:       return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            6:       return x << y[4:0];
            default: return x >> y[4:0];
        endcase
    endfunction

    // Past the end of the table the core spins on the final self jump.
    function automatic word_t expected_fetch(input int i);
        return exp_fetch[(i < exp_fetch.size()) ? i : exp_fetch.size() - 1];
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic place_instr(input word_t instr, input logic runs);
        ram.mem[emit_pc[9:2]] = instr;
        if (runs)
            exp_fetch.push_back(emit_pc);
        emit_pc = emit_pc + 32'd4;
    endtask

    task automatic expect_store(input word_t adr, input word_t dat, input logic [3:0] sel);
        exp_st_adr.push_back(adr);
        exp_st_dat.push_back(dat);
        exp_st_sel.push_back(sel);
    endtask

    task automatic load_const(input reg_idx_t rd, input word_t value);
        word_t upper;
        upper = value + 32'h800;
        place_instr(utype(upper[31:12], rd), 1'b1);
        place_instr(itype(value[11:0], rd, F3_ADD, rd, OPC_OP_IMM), 1'b1);
    endtask

    // ----------------------------------------------------------
    // Bus checks
    // ----------------------------------------------------------
    assign data_due = (fetched_opc == OPC_LOAD) || (fetched_opc == OPC_STORE);

    a_reset_quiet: assert property (@(posedge clk)
        (edge_cnt > 0) && (!reset_n || $rose(reset_n)) |-> !wb_stb && !wb_cyc && !wb_we)
        else flag_error("bus strobe, cycle or write active during reset");

    a_bus_levels: assert property (@(posedge clk) disable iff (!reset_n)
        (wb_cyc == wb_stb) && (wb_stb || !wb_we))
        else flag_error("bus cycle or write level outside a strobe");

    a_fetch_spacing: assert property (@(posedge clk) disable iff (!reset_n)
        wb_stb && (slot <= 0) |-> ##1 !wb_stb [*2] ##1 (wb_stb == data_due)
        ##1 !wb_stb ##1 wb_stb)
        else flag_error("fetch and data strobes left the five-cycle pattern");

    // Slot 0 is the fetch cycle of an instruction, slot 3 its data access.
    always @(posedge clk)
    begin
        edge_cnt <= edge_cnt + 1;
        if (!reset_n)
        begin
            slot        <= -1;
            fetch_idx   <= 0;
            store_idx   <= 0;
            fetched_opc <= '0;
        end
        else if (wb_stb || slot >= 0)
        begin
            if (slot <= 0)
            begin
                assert (wb_stb && !wb_we && wb_sel == 4'hf)
                    else flag_error("fetch slot without a read strobe on all lanes");
                assert (wb_adr == expected_fetch(fetch_idx))
                    else flag_error($sformatf("fetch %0d address %h, expected %h",
                                              fetch_idx, wb_adr, expected_fetch(fetch_idx)));
                fetched_opc <= wb_dat_r[6:0];
                fetch_idx   <= fetch_idx + 1;
            end
            if (wb_stb && wb_we)
            begin
                if (store_idx < exp_st_adr.size())
                begin
                    assert (wb_adr == exp_st_adr[store_idx]
                            && wb_dat_w == exp_st_dat[store_idx]
                            && wb_sel == exp_st_sel[store_idx])
                        else flag_error($sformatf(
                            "store %0d wrote %h sel %b at %h, expected %h sel %b at %h",
                            store_idx, wb_dat_w, wb_sel, wb_adr, exp_st_dat[store_idx],
                            exp_st_sel[store_idx], exp_st_adr[store_idx]));
                end
                else
                    flag_error("store beyond the end of the expected store table");
                store_idx <= store_idx + 1;
            end
            slot <= (slot <= 0) ? 1 : ((slot == 4) ? 0 : slot + 1);
        end
    end

    // ----------------------------------------------------------
    // Program image and run control
    // ----------------------------------------------------------
    initial
    begin
        word_t a;
        word_t b;
        word_t r;
        word_t merged;
        word_t link;
        int    limit;
        int    cycles;
        logic  timed_out;

        clk     = 1'b0;
        reset_n = 1'b0;
        void'($urandom(32'h998e_f2c9));
        a = $urandom();
        b = $urandom();
        r = $urandom();

        for (int i = 0; i < 256; i++)
            ram.mem[i] = '0;
        emit_pc = RESET_ADDR;

        // x1 and x2 hold the random operands, x10 and x11 the data bases.
        load_const(5'd1, a);
        load_const(5'd2, b);
        place_instr(itype(12'h200, 5'd0, F3_ADD, 5'd10, OPC_OP_IMM), 1'b1);
        place_instr(itype(12'h240, 5'd0, F3_ADD, 5'd11, OPC_OP_IMM), 1'b1);

        for (int k = 0; k < 8; k++)
        begin
            place_instr(rtype((k == 1) ? 7'h20 : 7'h00, 5'd2, 5'd1, op_funct3(k), 5'd3), 1'b1);
            place_instr(stype(12'(4 * k), 5'd3, 5'd10, F3_WORD), 1'b1);
            expect_store(32'h200 + 4 * k, alu_rule(k, a, b), 4'hf);
        end

        place_instr(itype(r[11:0], 5'd1, F3_XOR, 5'd3, OPC_OP_IMM), 1'b1);
        place_instr(stype(12'd44, 5'd3, 5'd10, F3_WORD), 1'b1);
        expect_store(32'h22c, a ^ sext12(r[11:0]), 4'hf);
        place_instr(itype(r[23:12], 5'd1, F3_SLT, 5'd3, OPC_OP_IMM), 1'b1);
        place_instr(stype(12'd48, 5'd3, 5'd10, F3_WORD), 1'b1);
        expect_store(32'h230, ($signed(a) < $signed(sext12(r[23:12]))) ? 32'd1 : 32'd0, 4'hf);

        // Byte store into a known word, then read back as byte and word.
        merged = a;
        merged[8 * r[25:24] +: 8] = b[7:0];
        place_instr(stype(12'd0, 5'd1, 5'd11, F3_WORD), 1'b1);
        expect_store(32'h240, a, 4'hf);
        place_instr(stype({10'd0, r[25:24]}, 5'd2, 5'd11, F3_BYTE), 1'b1);
        expect_store(32'h240, {4{b[7:0]}}, 4'b0001 << r[25:24]);
        place_instr(itype({10'd0, r[25:24]}, 5'd11, F3_BYTE_U, 5'd4, OPC_LOAD), 1'b1);
        place_instr(stype(12'd32, 5'd4, 5'd10, F3_WORD), 1'b1);
        expect_store(32'h220, {24'd0, b[7:0]}, 4'hf);
        place_instr(itype(12'd0, 5'd11, F3_WORD, 5'd5, OPC_LOAD), 1'b1);
        place_instr(stype(12'd36, 5'd5, 5'd10, F3_WORD), 1'b1);
        expect_store(32'h224, merged, 4'hf);

        // Taken BEQ, fall-through BNE, JAL with link, then a self jump.
        place_instr(btype(13'd8, 5'd1, 5'd1, F3_BEQ), 1'b1);
        place_instr(itype(12'd1, 5'd0, F3_ADD, 5'd6, OPC_OP_IMM), 1'b0);
        place_instr(btype(13'd8, 5'd1, 5'd1, F3_BNE), 1'b1);
        link = emit_pc + 32'd4;
        place_instr(jtype(21'd8, 5'd7), 1'b1);
        place_instr(itype(12'd1, 5'd0, F3_ADD, 5'd6, OPC_OP_IMM), 1'b0);
        place_instr(stype(12'd40, 5'd7, 5'd10, F3_WORD), 1'b1);
        expect_store(32'h228, link, 4'hf);
        place_instr(jtype(21'd0, 5'd0), 1'b1);

        limit = (exp_fetch.size() + 2) * 5 + MARGIN;

        repeat (2) @(posedge clk);
        #1 reset_n = 1'b1;

        cycles = 0;
        while ((fetch_idx < exp_fetch.size() + 2) && (cycles < limit))
        begin
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);

        timed_out = (cycles >= limit);
        if (timed_out)
            $display("Timeout: run stopped after %0d cycles with %0d of %0d fetches seen",
                     cycles, fetch_idx, exp_fetch.size() + 2);
        assert (ram.log_adr.size() == exp_st_adr.size())
            else flag_error($sformatf("memory recorded %0d writes, expected %0d",
                                      ram.log_adr.size(), exp_st_adr.size()));

        $display("Run done: %0d errors, %0d fetches, %0d stores", errors, fetch_idx, store_idx);
        if (errors == 0 && !timed_out)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* rv_core.f */
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_exec.sv
rtl/rv_memory.sv
rtl/rv_write.sv
rtl/rv_regfile.sv
rtl/rv_core.sv
dv/wb_ram_model.sv
dv/rv_core_tb.sv
